//--- src/cart_config.svh
//////////////////////////////
// Shared widths, cartridge header addresses, region codes and
// product IDs for the cartridge loading front end
//////////////////////////////
`ifndef CART_CONFIG_SVH
`define CART_CONFIG_SVH

`define LD_DATA_W        16
`define LD_ADDR_W        25
// Valid strobe, flags, address, compare, replace
`define CHEAT_W          129

// Product code words and the quirk decision point
`define HDR_ID_FIRST     'h182
`define HDR_ID_LAST      'h18A
`define HDR_QUIRK_ADDR   'h18C
`define HDR_REGION_ADDR0 'h1F0
`define HDR_REGION_ADDR1 'h1F2
`define HDR_END_ADDR     'h200

`define REGION_JP        2'd0
`define REGION_US        2'd1
`define REGION_EU        2'd2

`define SECTOR_COUNT_W   7

// Known product codes, eight ASCII characters each
`define ID_SRAM_0        64'("T-081276")
`define ID_SRAM_1        64'("T-81406 ")
`define ID_EEPROM_0      64'("MK-1215 ")
`define ID_EEPROM_1      64'("G-4060  ")
`define ID_SVP_0         64'("MK-1229 ")

`endif

//--- src/cart_pkg.sv
//////////////////////////////
// Types shared by the loader blocks and the testbench
//////////////////////////////
`include "cart_config.svh"

package cart_pkg;

	// Host download word, taken either whole or byte by byte
	// bytes[1] is the high byte, bytes[0] the low byte
	typedef union packed {
		logic [`LD_DATA_W-1:0]         word;
		logic [`LD_DATA_W/8-1:0][7:0]  bytes;
	} ld_word_t;

endpackage

//--- src/rom_write_ctrl.sv
//////////////////////////////
// Forwards cart download words to ROM memory over a toggle
// request/ack pair, stalls the host and records the ROM size
//////////////////////////////
`timescale 1ns/10ps
`include "cart_config.svh"

module rom_write_ctrl
	import cart_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  rst,
	input  logic                  cart_download,
	input  logic                  ioctl_wr,
	input  logic [`LD_ADDR_W-1:0] ioctl_addr,
	input  ld_word_t              ioctl_data,
	input  logic                  rom_wrack,
	output logic                  ioctl_wait,
	output logic                  rom_wr,
	output logic [`LD_ADDR_W-1:0] rom_addr,
	output logic [`LD_DATA_W-1:0] rom_din,
	output logic [`LD_ADDR_W-1:0] rom_sz
);

	logic old_download;
	logic download_end;

	// Memory expects big endian words
	assign rom_din  = {ioctl_data.bytes[0], ioctl_data.bytes[1]};
	assign rom_addr = cart_download ? ioctl_addr : rom_sz;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			old_download <= 1'b0;
			download_end <= 1'b0;
			ioctl_wait   <= 1'b0;
			rom_wr       <= 1'b0;
			rom_sz       <= '0;
		end else begin
			old_download <= cart_download;
			download_end <= old_download & ~cart_download;

			// Host address still holds the last write here
			if (download_end) begin
				rom_sz     <= ioctl_addr;
				ioctl_wait <= 1'b0;
			end

			if (~old_download & cart_download) begin
				rom_wr <= 1'b0;
			end else if (cart_download) begin
				if (ioctl_wr) begin
					ioctl_wait <= 1'b1;
					rom_wr     <= ~rom_wr;
				end else if (ioctl_wait && (rom_wr == rom_wrack)) begin
					ioctl_wait <= 1'b0;
				end
			end
		end
	end

endmodule

//--- src/header_scan.sv
//////////////////////////////
// Watches cart header words for region letters and the product
// code, and raises quirk flags for known titles
//////////////////////////////
`timescale 1ns/10ps
`include "cart_config.svh"

module header_scan
	import cart_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  rst,
	input  logic                  cart_download,
	input  logic                  ioctl_wr,
	input  logic [`LD_ADDR_W-1:0] ioctl_addr,
	input  ld_word_t              ioctl_data,
	output logic                  hdr_j,
	output logic                  hdr_u,
	output logic                  hdr_e,
	output logic                  hdr_ready,
	output logic                  sram_quirk,
	output logic                  eeprom_quirk,
	output logic                  svp_quirk
);

	logic        old_download;
	logic        cart_wr;
	logic [2:0]  lo_class;
	logic [2:0]  hi_class;
	logic [2:0]  letter_hit;
	logic [63:0] cart_id;

	// Returns {J, U, other} for one header character
	function automatic logic [2:0] region_letter(input logic [7:0] ch);
		if (ch == "J")
			return 3'b100;
		else if (ch == "U")
			return 3'b010;
		else if (ch >= "0" && ch <= "Z")
			return 3'b001;
		else
			return 3'b000;
	endfunction

	assign cart_wr  = ioctl_wr & cart_download;
	assign lo_class = region_letter(ioctl_data.bytes[0]);
	assign hi_class = region_letter(ioctl_data.bytes[1]);

	// Both region words carry a letter in the low byte, the first one also in the high byte
	always_comb begin
		letter_hit = 3'b000;
		if (ioctl_addr == `HDR_REGION_ADDR0 || ioctl_addr == `HDR_REGION_ADDR1)
			letter_hit = letter_hit | lo_class;
		if (ioctl_addr == `HDR_REGION_ADDR0)
			letter_hit = letter_hit | hi_class;
	end

	////////////////////////////// Region flags
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			old_download       <= 1'b0;
			{hdr_j, hdr_u, hdr_e} <= 3'b000;
			hdr_ready          <= 1'b0;
		end else begin
			old_download <= cart_download;
			if (~old_download & cart_download)
				{hdr_j, hdr_u, hdr_e} <= 3'b000;
			else if (cart_wr)
				{hdr_j, hdr_u, hdr_e} <= {hdr_j, hdr_u, hdr_e} | letter_hit;

			if (old_download & ~cart_download)
				hdr_ready <= 1'b0;
			else if (cart_wr && ioctl_addr == `HDR_END_ADDR)
				hdr_ready <= 1'b1;
		end
	end

	////////////////////////////// Product code
	// First and last words contribute one character each
	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			if (ioctl_addr == `HDR_ID_FIRST)
				cart_id[63:56] <= ioctl_data.bytes[1];
			if (ioctl_addr == (`HDR_ID_FIRST + 2))
				cart_id[55:40] <= {ioctl_data.bytes[0], ioctl_data.bytes[1]};
			if (ioctl_addr == (`HDR_ID_FIRST + 4))
				cart_id[39:24] <= {ioctl_data.bytes[0], ioctl_data.bytes[1]};
			if (ioctl_addr == (`HDR_ID_FIRST + 6))
				cart_id[23:8] <= {ioctl_data.bytes[0], ioctl_data.bytes[1]};
			if (ioctl_addr == `HDR_ID_LAST)
				cart_id[7:0] <= ioctl_data.bytes[0];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst || (~old_download & cart_download)) begin
			{sram_quirk, eeprom_quirk, svp_quirk} <= 3'b000;
		end else if (cart_wr && ioctl_addr == `HDR_QUIRK_ADDR) begin
			if (cart_id == `ID_SRAM_0 || cart_id == `ID_SRAM_1)
				sram_quirk <= 1'b1;
			if (cart_id == `ID_EEPROM_0 || cart_id == `ID_EEPROM_1)
				eeprom_quirk <= 1'b1;
			if (cart_id == `ID_SVP_0)
				svp_quirk <= 1'b1;
		end
	end

endmodule

//--- src/region_select.sv
//////////////////////////////
// Chooses the console region once the header has been seen
//////////////////////////////
`timescale 1ns/10ps
`include "cart_config.svh"

module region_select (
	input  logic       clk_sys,
	input  logic       rst,
	input  logic       region_auto,
	input  logic       region_from_header,
	input  logic [1:0] region_priority,
	input  logic [1:0] file_region,
	input  logic       hdr_j,
	input  logic       hdr_u,
	input  logic       hdr_e,
	input  logic       hdr_ready,
	output logic [1:0] region_req,
	output logic       region_set
);

	logic ready_d1;
	logic ready_d2;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			ready_d1   <= 1'b0;
			ready_d2   <= 1'b0;
			region_req <= `REGION_JP;
			region_set <= 1'b0;
		end else begin
			ready_d1 <= hdr_ready;
			ready_d2 <= ready_d1;

			if (region_auto & ready_d1 & ~ready_d2) begin
				if (region_from_header) begin
					region_set <= 1'b1;
					// First letter found wins, else the order's first region
					case (region_priority)
						2'd0: region_req <= hdr_u ? `REGION_US : hdr_e ? `REGION_EU :
							hdr_j ? `REGION_JP : `REGION_US;
						2'd1: region_req <= hdr_e ? `REGION_EU : hdr_u ? `REGION_US :
							hdr_j ? `REGION_JP : `REGION_EU;
						2'd2: region_req <= hdr_u ? `REGION_US : hdr_j ? `REGION_JP :
							hdr_e ? `REGION_EU : `REGION_US;
						default: region_req <= hdr_j ? `REGION_JP : hdr_u ? `REGION_US :
							hdr_e ? `REGION_EU : `REGION_JP;
					endcase
				end else begin
					region_set <= |file_region;
					region_req <= file_region;
				end
			end

			if (ready_d2 & ~ready_d1)
				region_set <= 1'b0;
		end
	end

endmodule

//--- src/cheat_loader.sv
//////////////////////////////
// Builds one cheat code from eight download words and strobes it
//////////////////////////////
`timescale 1ns/10ps
`include "cart_config.svh"

module cheat_loader
	import cart_pkg::*;
(
	input  logic                clk_sys,
	input  logic                rst,
	input  logic                code_download,
	input  logic                ioctl_wr,
	input  logic [3:0]          ioctl_addr,
	input  ld_word_t            ioctl_data,
	output logic [`CHEAT_W-1:0] cheat_code
);

	logic                cheat_valid;
	logic [`CHEAT_W-2:0] cheat_fields;

	assign cheat_code = {cheat_valid, cheat_fields};

	// Valid strobe lasts one cycle after the replace top word
	always_ff @(posedge clk_sys) begin
		if (rst)
			cheat_valid <= 1'b0;
		else
			cheat_valid <= code_download & ioctl_wr & (ioctl_addr == 4'd14);
	end

	// Bottom word lands at the lower even offset, top word at the next
	always_ff @(posedge clk_sys) begin
		if (code_download & ioctl_wr) begin
			case (ioctl_addr)
				4'd0:  cheat_fields[111:96]  <= ioctl_data.word;
				4'd2:  cheat_fields[127:112] <= ioctl_data.word;
				4'd4:  cheat_fields[79:64]   <= ioctl_data.word;
				4'd6:  cheat_fields[95:80]   <= ioctl_data.word;
				4'd8:  cheat_fields[47:32]   <= ioctl_data.word;
				4'd10: cheat_fields[63:48]   <= ioctl_data.word;
				4'd12: cheat_fields[15:0]    <= ioctl_data.word;
				4'd14: cheat_fields[31:16]   <= ioctl_data.word;
				default: ;
			endcase
		end
	end

endmodule

//--- src/backup_sequencer.sv
//////////////////////////////
// Moves backup RAM sector by sector between the core and a
// mounted save image, with optional autosave on menu open
//////////////////////////////
`timescale 1ns/10ps
`include "cart_config.svh"

module backup_sequencer (
	input  logic                       clk_sys,
	input  logic                       rst,
	input  logic                       bk_ena,
	input  logic                       cart_download,
	input  logic                       img_size_nz,
	input  logic                       bk_change,
	input  logic                       bk_load,
	input  logic                       bk_save_req,
	input  logic                       autosave,
	input  logic                       osd_status,
	input  logic                       sd_ack,
	output logic                       sd_rd,
	output logic                       sd_wr,
	output logic [`SECTOR_COUNT_W-1:0] sd_lba,
	output logic                       bk_loading,
	output logic                       bk_busy,
	output logic                       sav_pending
);

	logic old_load;
	logic old_save;
	logic old_ack;
	logic old_download;
	logic old_change;
	logic bk_save;
	logic go_load;
	logic go_save;

	// A pending autosave fires as soon as the menu opens
	assign bk_save = bk_save_req | (sav_pending & osd_status);
	assign go_load = (~old_load & bk_load) | (old_download & ~cart_download & img_size_nz);
	assign go_save = ~old_save & bk_save & ~go_load;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			old_load     <= 1'b0;
			old_save     <= 1'b0;
			old_ack      <= 1'b0;
			old_download <= 1'b0;
			old_change   <= 1'b0;
			sd_rd        <= 1'b0;
			sd_wr        <= 1'b0;
			sd_lba       <= '0;
			bk_loading   <= 1'b0;
			bk_busy      <= 1'b0;
			sav_pending  <= 1'b0;
		end else begin
			old_load     <= bk_load;
			old_save     <= bk_save;
			old_ack      <= sd_ack;
			old_download <= cart_download;
			old_change   <= bk_change;

			if (~old_change & bk_change & ~osd_status)
				sav_pending <= autosave;
			else if (bk_busy)
				sav_pending <= 1'b0;

			// Request drops as soon as storage picks it up
			if (~old_ack & sd_ack)
				{sd_rd, sd_wr} <= 2'b00;

			////////////////////////////// Sector stepping
			if (!bk_busy) begin
				if (bk_ena & (go_load | go_save)) begin
					bk_busy    <= 1'b1;
					bk_loading <= go_load;
					sd_lba     <= '0;
					sd_rd      <= go_load;
					sd_wr      <= ~go_load;
				end
			end else if (old_ack & ~sd_ack) begin
				if (&sd_lba) begin
					bk_busy    <= 1'b0;
					bk_loading <= 1'b0;
				end else begin
					sd_lba <= sd_lba + 1'b1;
					sd_rd  <= bk_loading;
					sd_wr  <= ~bk_loading;
				end
			end
		end
	end

endmodule

//--- src/cart_frontend.sv
//////////////////////////////
// Cartridge loading front end. Splits the host download into
// cart and cheat streams and connects the loader blocks
//////////////////////////////
`timescale 1ns/10ps
`include "cart_config.svh"

module cart_frontend
	import cart_pkg::*;
(
	input  logic                       clk_sys,
	input  logic                       rst,
	input  logic                       ioctl_download,
	input  logic [7:0]                 ioctl_index,
	input  logic                       ioctl_wr,
	input  logic [`LD_ADDR_W-1:0]      ioctl_addr,
	input  ld_word_t                   ioctl_data,
	input  logic                       rom_wrack,
	input  logic                       region_auto,
	input  logic                       region_from_header,
	input  logic [1:0]                 region_priority,
	input  logic                       sd_ack,
	input  logic                       img_mounted,
	input  logic                       img_readonly,
	input  logic                       img_size_nz,
	input  logic                       bk_change,
	input  logic                       bk_load,
	input  logic                       bk_save_req,
	input  logic                       autosave,
	input  logic                       osd_status,
	output logic                       ioctl_wait,
	output logic                       rom_wr,
	output logic [`LD_ADDR_W-1:0]      rom_addr,
	output logic [`LD_DATA_W-1:0]      rom_din,
	output logic [`LD_ADDR_W-1:0]      rom_sz,
	output logic                       sram_quirk,
	output logic                       eeprom_quirk,
	output logic                       svp_quirk,
	output logic [1:0]                 region_req,
	output logic                       region_set,
	output logic [`CHEAT_W-1:0]        cheat_code,
	output logic                       cheat_reset,
	output logic                       sd_rd,
	output logic                       sd_wr,
	output logic [`SECTOR_COUNT_W-1:0] sd_lba,
	output logic                       bk_loading,
	output logic                       bk_busy,
	output logic                       bk_ena,
	output logic                       sav_pending
);

	logic code_download;
	logic cart_download;
	logic old_download;
	logic hdr_j;
	logic hdr_u;
	logic hdr_e;
	logic hdr_ready;

	// Index with every bit set carries cheat codes
	assign code_download = ioctl_download & (&ioctl_index);
	assign cart_download = ioctl_download & ~(&ioctl_index);
	assign cheat_reset   = code_download & ioctl_wr & (ioctl_addr == '0);

	// Save image gets mounted while the cart is still downloading
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			old_download <= 1'b0;
			bk_ena       <= 1'b0;
		end else begin
			old_download <= cart_download;
			if (~old_download & cart_download)
				bk_ena <= 1'b0;
			else if (cart_download & img_mounted & ~img_readonly)
				bk_ena <= 1'b1;
		end
	end

	rom_write_ctrl u_rom_write_ctrl (
		.clk_sys, .rst, .cart_download, .ioctl_wr, .ioctl_addr, .ioctl_data,
		.rom_wrack, .ioctl_wait, .rom_wr, .rom_addr, .rom_din, .rom_sz
	);

	header_scan u_header_scan (
		.clk_sys, .rst, .cart_download, .ioctl_wr, .ioctl_addr, .ioctl_data,
		.hdr_j, .hdr_u, .hdr_e, .hdr_ready, .sram_quirk, .eeprom_quirk, .svp_quirk
	);

	region_select u_region_select (
		.clk_sys, .rst, .region_auto, .region_from_header, .region_priority,
		.file_region(ioctl_index[7:6]),
		.hdr_j, .hdr_u, .hdr_e, .hdr_ready, .region_req, .region_set
	);

	cheat_loader u_cheat_loader (
		.clk_sys, .rst, .code_download, .ioctl_wr,
		.ioctl_addr(ioctl_addr[3:0]),
		.ioctl_data, .cheat_code
	);

	backup_sequencer u_backup_sequencer (
		.clk_sys, .rst, .bk_ena, .cart_download, .img_size_nz, .bk_change, .bk_load,
		.bk_save_req, .autosave, .osd_status, .sd_ack, .sd_rd, .sd_wr, .sd_lba,
		.bk_loading, .bk_busy, .sav_pending
	);

endmodule

//--- tb/tb_cart_frontend.sv
//////////////////////////////
// Directed regression for the cartridge loading front end.
// Models the ROM memory and the backup storage side
//////////////////////////////
`timescale 1ns/10ps
`include "cart_config.svh"

module tb_cart_frontend
	import cart_pkg::*;
();

	// Three 128-sector backup runs make up most of the roughly 1200 cycles
	localparam int TIMEOUT_CYCLES = 4000;

	logic                       clk_sys;
	logic                       rst;
	logic                       ioctl_download;
	logic [7:0]                 ioctl_index;
	logic                       ioctl_wr;
	logic [`LD_ADDR_W-1:0]      ioctl_addr;
	ld_word_t                   ioctl_data;
	logic                       rom_wrack;
	logic                       region_auto;
	logic                       region_from_header;
	logic [1:0]                 region_priority;
	logic                       sd_ack;
	logic                       img_mounted;
	logic                       img_readonly;
	logic                       img_size_nz;
	logic                       bk_change;
	logic                       bk_load;
	logic                       bk_save_req;
	logic                       autosave;
	logic                       osd_status;
	logic                       ioctl_wait;
	logic                       rom_wr;
	logic [`LD_ADDR_W-1:0]      rom_addr;
	logic [`LD_DATA_W-1:0]      rom_din;
	logic [`LD_ADDR_W-1:0]      rom_sz;
	logic                       sram_quirk;
	logic                       eeprom_quirk;
	logic                       svp_quirk;
	logic [1:0]                 region_req;
	logic                       region_set;
	logic [`CHEAT_W-1:0]        cheat_code;
	logic                       cheat_reset;
	logic                       sd_rd;
	logic                       sd_wr;
	logic [`SECTOR_COUNT_W-1:0] sd_lba;
	logic                       bk_loading;
	logic                       bk_busy;
	logic                       bk_ena;
	logic                       sav_pending;
	int unsigned                cycle_count = 0;
	int                         ack_delay = -1;

	cart_frontend UUT (.*);

	always #5 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Regression failed");
			$fatal(1, "Timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		end
	end

	////////////////////////////// Memory and storage models
	// ROM memory mirrors each toggle after 0 to 3 cycles
	always @(posedge clk_sys) begin
		#1;
		if (rom_wrack != rom_wr) begin
			if (ack_delay < 0)
				ack_delay = $urandom % 4;
			if (ack_delay == 0) begin
				rom_wrack = rom_wr;
				ack_delay = -1;
			end else begin
				ack_delay = ack_delay - 1;
			end
		end
	end

	// One-cycle ack per sector request
	always @(posedge clk_sys) begin
		#1;
		sd_ack = (sd_rd | sd_wr) & ~sd_ack;
	end

	////////////////////////////// Compare tasks
	task automatic report_mismatch(input string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		$display("Regression failed");
		$fatal(1, "Stopped at the first mismatch");
	endtask

	task automatic check_word(input ld_word_t actual, input ld_word_t expected, input string what);
		if (actual !== expected)
			report_mismatch($sformatf("%s is %h, expected %h", what, actual.word, expected.word));
	endtask

	task automatic check_flag(input logic actual, input logic expected, input string what);
		if (actual !== expected)
			report_mismatch($sformatf("%s is %b, expected %b", what, actual, expected));
	endtask

	task automatic check_region(input logic [1:0] actual, input logic [1:0] expected,
		input string what);
		if (actual !== expected)
			report_mismatch($sformatf("%s is %0d, expected %0d", what, actual, expected));
	endtask

	task automatic check_lba(input logic [`SECTOR_COUNT_W-1:0] actual,
		input logic [`SECTOR_COUNT_W-1:0] expected, input string what);
		if (actual !== expected)
			report_mismatch($sformatf("%s is %0d, expected %0d", what, actual, expected));
	endtask

	task automatic check_code(input logic [`CHEAT_W-1:0] actual,
		input logic [`CHEAT_W-1:0] expected, input string what);
		if (actual !== expected)
			report_mismatch($sformatf("%s is %h, expected %h", what, actual, expected));
	endtask

	task automatic check_addr(input logic [`LD_ADDR_W-1:0] actual,
		input logic [`LD_ADDR_W-1:0] expected, input string what);
		if (actual !== expected)
			report_mismatch($sformatf("%s is %h, expected %h", what, actual, expected));
	endtask

	task automatic check_quirks(input logic [2:0] expected, input string when);
		check_flag(sram_quirk, expected[2], {"sram_quirk ", when});
		check_flag(eeprom_quirk, expected[1], {"eeprom_quirk ", when});
		check_flag(svp_quirk, expected[0], {"svp_quirk ", when});
	endtask

	////////////////////////////// Host side helpers
	// Drive point just after the next rising edge
	task automatic tick();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic start_download(input logic [7:0] index);
		ioctl_download = 1'b1;
		ioctl_index    = index;
		tick();
		tick();
		while (rom_wr != rom_wrack)
			tick();
	endtask

	task automatic end_download();
		ioctl_download = 1'b0;
		repeat (4) tick();
	endtask

	// One cart word, then hold off until the memory has caught up
	task automatic cart_write(input logic [`LD_ADDR_W-1:0] addr, input ld_word_t data);
		logic     prev_wr;
		ld_word_t swapped;
		prev_wr          = rom_wr;
		swapped.bytes[1] = data.bytes[0];
		swapped.bytes[0] = data.bytes[1];
		ioctl_addr       = addr;
		ioctl_data       = data;
		ioctl_wr         = 1'b1;
		#1;
		check_word(rom_din, swapped, "rom_din");
		check_addr(rom_addr, addr, "rom_addr");
		tick();
		ioctl_wr = 1'b0;
		check_flag(rom_wr, ~prev_wr, "rom_wr toggle");
		check_flag(ioctl_wait, 1'b1, "ioctl_wait after write");
		while (ioctl_wait)
			tick();
		check_flag(rom_wrack == rom_wr, 1'b1, "rom_wrack matching rom_wr");
	endtask

	task automatic cheat_write(input logic [`LD_ADDR_W-1:0] addr, input ld_word_t data);
		ioctl_addr = addr;
		ioctl_data = data;
		ioctl_wr   = 1'b1;
		#1;
		check_flag(cheat_reset, addr == 0, "cheat_reset");
		tick();
		ioctl_wr = 1'b0;
	endtask

	// ROM byte b sits in the low byte of word b, byte b+1 in the high byte
	function automatic logic [7:0] code_char(input logic [63:0] code, input int idx);
		if (idx < 0 || idx > 7)
			return " ";
		return code[63 - 8 * idx -: 8];
	endfunction

	function automatic ld_word_t code_word(input logic [63:0] code, input int addr);
		ld_word_t w;
		w.bytes[0] = code_char(code, addr - 'h183);
		w.bytes[1] = code_char(code, addr - 'h182);
		return w;
	endfunction

	task automatic load_header(input logic [63:0] code, input ld_word_t letters);
		int addr;
		for (addr = `HDR_ID_FIRST; addr <= `HDR_ID_LAST; addr += 2)
			cart_write(`LD_ADDR_W'(addr), code_word(code, addr));
		cart_write(`HDR_QUIRK_ADDR, '0);
		cart_write(`HDR_REGION_ADDR0, letters);
		cart_write(`HDR_REGION_ADDR1, "  ");
		cart_write(`HDR_END_ADDR, '0);
		repeat (3) tick();
	endtask

	task automatic run_sectors(input logic is_load);
		int i;
		for (i = 0; i < (1 << `SECTOR_COUNT_W); i++) begin
			while (!sd_rd && !sd_wr)
				tick();
			check_flag(sd_rd, is_load, "sd_rd");
			check_flag(sd_wr, !is_load, "sd_wr");
			check_lba(sd_lba, `SECTOR_COUNT_W'(i), "sd_lba");
			check_flag(bk_busy, 1'b1, "bk_busy during transfer");
			check_flag(bk_loading, is_load, "bk_loading");
			while (sd_rd || sd_wr)
				tick();
		end
		while (bk_busy)
			tick();
		check_flag(bk_loading, 1'b0, "bk_loading after transfer");
	endtask

	////////////////////////////// Tests
	task automatic test_rom_write();
		ld_word_t data;
		int       i;
		start_download(8'h01);
		for (i = 0; i < 20; i++) begin
			data.word = `LD_DATA_W'($urandom);
			cart_write(`LD_ADDR_W'(2 * i), data);
		end
		end_download();
		// Even count of toggles brings rom_wr back to zero
		check_flag(rom_wr, 1'b0, "rom_wr after 20 writes");
		check_addr(rom_sz, `LD_ADDR_W'(38), "rom_sz");
		check_addr(rom_addr, `LD_ADDR_W'(38), "rom_addr after download");
	endtask

	task automatic run_region_case(input logic [7:0] index, input logic from_header,
		input logic [1:0] prio, input ld_word_t letters, input logic [1:0] expected);
		region_from_header = from_header;
		region_priority    = prio;
		start_download(index);
		load_header(64'("GM 00001"), letters);
		check_region(region_req, expected, "region_req");
		check_flag(region_set, 1'b1, "region_set with header ready");
		end_download();
		check_flag(region_set, 1'b0, "region_set after download");
	endtask

	task automatic test_region();
		region_auto = 1'b1;
		run_region_case(8'h00, 1'b1, 2'd0, {"U", "E"}, `REGION_US);
		run_region_case(8'h00, 1'b1, 2'd1, {"U", "E"}, `REGION_EU);
		// Without letters the JP>US>EU order falls back to JP
		run_region_case(8'h00, 1'b1, 2'd3, "  ", `REGION_JP);
		run_region_case(8'h80, 1'b0, 2'd0, "  ", `REGION_EU);
		region_auto = 1'b0;
	endtask

	task automatic test_quirks();
		start_download(8'h00);
		load_header(`ID_EEPROM_0, "  ");
		check_quirks(3'b010, "for EEPROM title");
		end_download();
		start_download(8'h00);
		check_quirks(3'b000, "after new download");
		load_header(64'("NOT-A-ID"), "  ");
		check_quirks(3'b000, "for unknown title");
		end_download();
	endtask

	task automatic test_cheat();
		ld_word_t            w [8];
		logic [`CHEAT_W-1:0] expected;
		int                  i;
		for (i = 0; i < 8; i++)
			w[i].word = `LD_DATA_W'($urandom);
		// Valid, flags, address, compare, replace from the top down
		expected = {1'b1, w[1].word, w[0].word, w[3].word, w[2].word,
			w[5].word, w[4].word, w[7].word, w[6].word};
		ioctl_download = 1'b1;
		ioctl_index    = 8'hFF;
		tick();
		for (i = 0; i < 8; i++) begin
			check_flag(cheat_code[`CHEAT_W-1], 1'b0, "cheat valid before last word");
			cheat_write(`LD_ADDR_W'(2 * i), w[i]);
		end
		check_code(cheat_code, expected, "cheat_code");
		tick();
		check_flag(cheat_code[`CHEAT_W-1], 1'b0, "cheat valid after pulse");
		ioctl_download = 1'b0;
		tick();
	endtask

	task automatic test_backup();
		start_download(8'h00);
		img_mounted = 1'b1;
		tick();
		img_mounted = 1'b0;
		tick();
		check_flag(bk_ena, 1'b1, "bk_ena after writable mount");
		img_size_nz    = 1'b1;
		ioctl_download = 1'b0;
		run_sectors(1'b1);
		bk_save_req = 1'b1;
		tick();
		bk_save_req = 1'b0;
		run_sectors(1'b0);
	endtask

	task automatic test_autosave();
		autosave   = 1'b1;
		osd_status = 1'b0;
		bk_change  = 1'b1;
		tick();
		bk_change = 1'b0;
		check_flag(sav_pending, 1'b1, "sav_pending after bk_change");
		tick();
		check_flag(bk_busy, 1'b0, "bk_busy with menu closed");
		osd_status = 1'b1;
		run_sectors(1'b0);
		check_flag(sav_pending, 1'b0, "sav_pending after autosave");
		osd_status = 1'b0;
	endtask

	initial begin
		void'($urandom(32'he19b87ed));
		clk_sys            = 1'b0;
		rst                = 1'b1;
		ioctl_download     = 1'b0;
		ioctl_index        = 8'h00;
		ioctl_wr           = 1'b0;
		ioctl_addr         = '0;
		ioctl_data         = '0;
		rom_wrack          = 1'b0;
		region_auto        = 1'b0;
		region_from_header = 1'b0;
		region_priority    = 2'd0;
		sd_ack             = 1'b0;
		img_mounted        = 1'b0;
		img_readonly       = 1'b0;
		img_size_nz        = 1'b0;
		bk_change          = 1'b0;
		bk_load            = 1'b0;
		bk_save_req        = 1'b0;
		autosave           = 1'b0;
		osd_status         = 1'b0;
		repeat (4) @(posedge clk_sys);
		#1;
		rst = 1'b0;
		tick();
		test_rom_write();
		test_region();
		test_quirks();
		test_cheat();
		test_backup();
		test_autosave();
		$display("Regression passed");
		$finish;
	end

endmodule

//--- sim.f
+incdir+src
src/cart_pkg.sv
src/rom_write_ctrl.sv
src/header_scan.sv
src/region_select.sv
src/cheat_loader.sv
src/backup_sequencer.sv
src/cart_frontend.sv
tb/tb_cart_frontend.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the cart front end regression with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_cart_frontend -f sim.f -o tb_sim \
	&& ./obj_dir/tb_sim | tee sim.log
grep -q "Regression passed" sim.log && echo "Simulation PASS" || { echo "Simulation FAIL"; exit 1; }
